//--- cpu_ctrl_defines.svh
`ifndef CPU_CTRL_DEFINES_SVH
`define CPU_CTRL_DEFINES_SVH

// data word width, also the width of ALU operands and offsets
`define WORD 32

// one instruction, and the register-list mask of the list instructions
`define HALF_WORD 16

// the register list in an STM or PUSH encoding is one byte wide
`define BYTE 8

// register number width, sixteen architectural registers
`define ADDR_WIDTH 4

// stack pointer register number
`define SP_REG_NUM 13

// link register, the extra register that bit 8 of PUSH adds to the list
`define LR_REG_NUM 14

// address step between two consecutive registers in memory
`define WORD_BYTES 4

`endif

//--- cpu_ctrl_pkg.sv
`include "cpu_ctrl_defines.svh"

package cpu_ctrl_pkg;

    // one 16-bit instruction
    typedef logic [`HALF_WORD-1:0] instr_t;

    // a data value or an address offset
    typedef logic [`WORD-1:0] word_t;

    // register number
    typedef logic [`ADDR_WIDTH-1:0] reg_addr_t;

    // one bit per register, bit i stands for register i
    typedef logic [`HALF_WORD-1:0] reg_list_t;

    // number of registers in a list, 0 up to and including 16
    typedef logic [$clog2(`HALF_WORD+1)-1:0] step_count_t;

    // operation for the execute stage
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_LSL,
        ALU_LSR,
        ALU_ASR,
        ALU_ROR,
        ALU_MUL,
        ALU_BIC,
        ALU_NOT
    } alu_op_e;

    // operand source, SRC_ACCUM is the offset from the list sequencer
    typedef enum logic [1:0] {
        SRC_REG,
        SRC_IMM,
        SRC_ZERO,
        SRC_ACCUM
    } alu_src_e;

    // what the write-back stage puts into the register file
    typedef enum logic {
        RF_FROM_ALU,
        RF_FROM_MEM
    } rf_data_src_e;

    // register addresses come from the instruction fields or from reg_addr_o
    typedef enum logic {
        ADDR_FROM_INSTR,
        ADDR_FROM_CTRL
    } addr_src_e;

    typedef enum logic [1:0] {
        LIST_NONE,
        LIST_STORE,
        LIST_PUSH
    } list_kind_e;

    // control word handed to the later pipeline stages
    typedef struct packed {
        logic         update_flag;
        logic         mem_read;
        logic         mem_write;
        logic         reg_write;
        rf_data_src_e rf_data_src;
        alu_src_e     alu_src_1;
        alu_src_e     alu_src_2;
        alu_op_e      alu_op;
        addr_src_e    addr_2_src;
        addr_src_e    dest_src;
        // store data from register 3 instead of register 2
        logic         sel_reg_3;
    } ctrl_word_t;

    // register-list request from the decoder to the sequencer
    typedef struct packed {
        list_kind_e kind;
        reg_list_t  reg_list;
        reg_addr_t  base;
    } list_req_t;

endpackage

//--- thumb_decode.sv
`timescale 1ns/1ps
`include "cpu_ctrl_defines.svh"

module thumb_decode (
    input  cpu_ctrl_pkg::instr_t     instr_i,
    output cpu_ctrl_pkg::ctrl_word_t ctrl_o,
    output cpu_ctrl_pkg::list_req_t  list_req_o,
    output logic                     valid_o
);

    // set by the single load/store classes, applied after the class decode
    logic mem_access;
    logic mem_load;

    always_comb begin
        // defaults describe a plain register-to-register add with nothing enabled
        ctrl_o.update_flag = 1'b0;
        ctrl_o.mem_read    = 1'b0;
        ctrl_o.mem_write   = 1'b0;
        ctrl_o.reg_write   = 1'b0;
        ctrl_o.rf_data_src = cpu_ctrl_pkg::RF_FROM_ALU;
        ctrl_o.alu_src_1   = cpu_ctrl_pkg::SRC_REG;
        ctrl_o.alu_src_2   = cpu_ctrl_pkg::SRC_REG;
        ctrl_o.alu_op      = cpu_ctrl_pkg::ALU_ADD;
        ctrl_o.addr_2_src  = cpu_ctrl_pkg::ADDR_FROM_INSTR;
        ctrl_o.dest_src    = cpu_ctrl_pkg::ADDR_FROM_INSTR;
        ctrl_o.sel_reg_3   = 1'b0;

        list_req_o.kind     = cpu_ctrl_pkg::LIST_NONE;
        list_req_o.reg_list = '0;
        list_req_o.base     = '0;

        valid_o    = 1'b1;
        mem_access = 1'b0;
        mem_load   = 1'b0;

        casez (instr_i[15:9])
            // shift by immediate, add/sub and the 8-bit immediate forms
            7'b00?_????: begin
                // everything here but CMP writes a result and sets the flags
                ctrl_o.update_flag = 1'b1;
                ctrl_o.reg_write   = 1'b1;
                casez (instr_i[13:9])
                    5'b000??: begin
                        ctrl_o.alu_op    = cpu_ctrl_pkg::ALU_LSL;
                        ctrl_o.alu_src_2 = cpu_ctrl_pkg::SRC_IMM;
                    end
                    5'b001??: begin
                        ctrl_o.alu_op    = cpu_ctrl_pkg::ALU_LSR;
                        ctrl_o.alu_src_2 = cpu_ctrl_pkg::SRC_IMM;
                    end
                    5'b010??: begin
                        ctrl_o.alu_op    = cpu_ctrl_pkg::ALU_ASR;
                        ctrl_o.alu_src_2 = cpu_ctrl_pkg::SRC_IMM;
                    end
                    5'b01100: ctrl_o.alu_op = cpu_ctrl_pkg::ALU_ADD;
                    5'b01101: ctrl_o.alu_op = cpu_ctrl_pkg::ALU_SUB;
                    5'b01110, 5'b110??: begin
                        ctrl_o.alu_src_2 = cpu_ctrl_pkg::SRC_IMM;
                    end
                    5'b01111, 5'b111??: begin
                        ctrl_o.alu_op    = cpu_ctrl_pkg::ALU_SUB;
                        ctrl_o.alu_src_2 = cpu_ctrl_pkg::SRC_IMM;
                    end
                    // move is computed as 0 + imm8
                    5'b100??: begin
                        ctrl_o.alu_src_1 = cpu_ctrl_pkg::SRC_ZERO;
                        ctrl_o.alu_src_2 = cpu_ctrl_pkg::SRC_IMM;
                    end
                    5'b101??: begin
                        ctrl_o.alu_op    = cpu_ctrl_pkg::ALU_SUB;
                        ctrl_o.alu_src_2 = cpu_ctrl_pkg::SRC_IMM;
                        ctrl_o.reg_write = 1'b0;
                    end
                endcase
            end
            // data processing, register operands only
            7'b010_000?: begin
                ctrl_o.update_flag = 1'b1;
                ctrl_o.reg_write   = 1'b1;
                case (instr_i[9:6])
                    4'b0000: ctrl_o.alu_op = cpu_ctrl_pkg::ALU_AND;
                    4'b0001: ctrl_o.alu_op = cpu_ctrl_pkg::ALU_XOR;
                    4'b0010: ctrl_o.alu_op = cpu_ctrl_pkg::ALU_LSL;
                    4'b0011: ctrl_o.alu_op = cpu_ctrl_pkg::ALU_LSR;
                    4'b0100: ctrl_o.alu_op = cpu_ctrl_pkg::ALU_ASR;
                    // carry-in is added by the execute stage from the flags
                    4'b0101: ctrl_o.alu_op = cpu_ctrl_pkg::ALU_ADD;
                    4'b0110: ctrl_o.alu_op = cpu_ctrl_pkg::ALU_SUB;
                    4'b0111: ctrl_o.alu_op = cpu_ctrl_pkg::ALU_ROR;
                    4'b1000: begin
                        ctrl_o.alu_op    = cpu_ctrl_pkg::ALU_AND;
                        ctrl_o.reg_write = 1'b0;
                    end
                    // negate is 0 - Rm
                    4'b1001: begin
                        ctrl_o.alu_op    = cpu_ctrl_pkg::ALU_SUB;
                        ctrl_o.alu_src_1 = cpu_ctrl_pkg::SRC_ZERO;
                    end
                    4'b1010: begin
                        ctrl_o.alu_op    = cpu_ctrl_pkg::ALU_SUB;
                        ctrl_o.reg_write = 1'b0;
                    end
                    4'b1011: begin
                        ctrl_o.alu_op    = cpu_ctrl_pkg::ALU_ADD;
                        ctrl_o.reg_write = 1'b0;
                    end
                    4'b1100: ctrl_o.alu_op = cpu_ctrl_pkg::ALU_OR;
                    4'b1101: ctrl_o.alu_op = cpu_ctrl_pkg::ALU_MUL;
                    4'b1110: ctrl_o.alu_op = cpu_ctrl_pkg::ALU_BIC;
                    4'b1111: ctrl_o.alu_op = cpu_ctrl_pkg::ALU_NOT;
                endcase
            end
            // register offset, the signed loads sit at 011 and 111 in bits 11:9
            7'b0101_???: begin
                mem_access = 1'b1;
                mem_load   = instr_i[11] || (instr_i[10:9] == 2'b11);
            end
            // word, byte, halfword and SP-relative immediate offsets, bit 11 is L
            7'b011_????, 7'b1000_???, 7'b1001_???: begin
                mem_access       = 1'b1;
                mem_load         = instr_i[11];
                ctrl_o.alu_src_2 = cpu_ctrl_pkg::SRC_IMM;
            end
            7'b1011_010: begin
                list_req_o.kind     = cpu_ctrl_pkg::LIST_PUSH;
                list_req_o.reg_list = cpu_ctrl_pkg::reg_list_t'(instr_i[`BYTE-1:0]);
                list_req_o.reg_list[`LR_REG_NUM] = instr_i[8];
                list_req_o.base     = cpu_ctrl_pkg::reg_addr_t'(`SP_REG_NUM);
                // the stack grows down, so offsets are taken off SP
                ctrl_o.alu_op       = cpu_ctrl_pkg::ALU_SUB;
                ctrl_o.alu_src_2    = cpu_ctrl_pkg::SRC_ACCUM;
            end
            7'b1100_0??: begin
                list_req_o.kind     = cpu_ctrl_pkg::LIST_STORE;
                list_req_o.reg_list = cpu_ctrl_pkg::reg_list_t'(instr_i[`BYTE-1:0]);
                list_req_o.base     = cpu_ctrl_pkg::reg_addr_t'(instr_i[10:8]);
                ctrl_o.alu_op       = cpu_ctrl_pkg::ALU_ADD;
                ctrl_o.alu_src_2    = cpu_ctrl_pkg::SRC_ACCUM;
            end
            default: valid_o = 1'b0;
        endcase

        if (mem_access) begin
            if (mem_load) begin
                ctrl_o.mem_read    = 1'b1;
                ctrl_o.reg_write   = 1'b1;
                ctrl_o.rf_data_src = cpu_ctrl_pkg::RF_FROM_MEM;
            end else begin
                ctrl_o.mem_write = 1'b1;
                ctrl_o.sel_reg_3 = 1'b1;
            end
        end
    end

endmodule

//--- reg_list_sequencer.sv
`timescale 1ns/1ps
`include "cpu_ctrl_defines.svh"

module reg_list_sequencer (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  cpu_ctrl_pkg::ctrl_word_t dec_ctrl_i,
    input  cpu_ctrl_pkg::list_req_t  list_req_i,
    output cpu_ctrl_pkg::ctrl_word_t ctrl_o,
    output logic                     stall_o,
    output cpu_ctrl_pkg::reg_addr_t  reg_addr_o,
    output cpu_ctrl_pkg::word_t      accum_imm_o
);

    // number of set bits in a register list
    function automatic cpu_ctrl_pkg::step_count_t count_regs(
        input cpu_ctrl_pkg::reg_list_t list
    );
        cpu_ctrl_pkg::step_count_t total;
        total = '0;
        for (int i = 0; i < `HALF_WORD; i++) begin
            total = total + cpu_ctrl_pkg::step_count_t'(list[i]);
        end
        return total;
    endfunction

    // register number of the lowest set bit, zero for an empty list
    function automatic cpu_ctrl_pkg::reg_addr_t lowest_reg(
        input cpu_ctrl_pkg::reg_list_t list
    );
        cpu_ctrl_pkg::reg_addr_t num;
        num = '0;
        for (int i = `HALF_WORD - 1; i >= 0; i--) begin
            if (list[i]) begin
                num = cpu_ctrl_pkg::reg_addr_t'(i);
            end
        end
        return num;
    endfunction

    // registers of the list not yet transferred have their bit still set here
    cpu_ctrl_pkg::reg_list_t   hold_mask;
    cpu_ctrl_pkg::step_count_t step_k;

    cpu_ctrl_pkg::reg_list_t   pending;
    cpu_ctrl_pkg::reg_list_t   lowest_bit;
    cpu_ctrl_pkg::step_count_t reg_count;
    cpu_ctrl_pkg::word_t       total_bytes;
    cpu_ctrl_pkg::word_t       step_bytes;
    logic                      is_list;
    logic                      is_push;
    logic                      busy;

    assign is_list = (list_req_i.kind != cpu_ctrl_pkg::LIST_NONE);
    assign is_push = (list_req_i.kind == cpu_ctrl_pkg::LIST_PUSH);
    assign pending = list_req_i.reg_list & hold_mask;

    // two's complement trick isolates the lowest set bit
    assign lowest_bit = pending & (~pending + 1'b1);

    assign busy    = is_list && (pending != '0);
    assign stall_o = busy;

    assign reg_count   = count_regs(list_req_i.reg_list);
    assign total_bytes = cpu_ctrl_pkg::word_t'(reg_count)
                         * cpu_ctrl_pkg::word_t'(`WORD_BYTES);
    assign step_bytes  = cpu_ctrl_pkg::word_t'(step_k)
                         * cpu_ctrl_pkg::word_t'(`WORD_BYTES);

    always_comb begin
        // alu_op and alu_src_2 of a list instruction are already set by the decoder
        ctrl_o      = dec_ctrl_i;
        reg_addr_o  = '0;
        accum_imm_o = '0;

        if (is_list) begin
            if (busy) begin
                // one register goes to memory, its number drives read port 2
                ctrl_o.mem_write  = 1'b1;
                ctrl_o.reg_write  = 1'b0;
                ctrl_o.addr_2_src = cpu_ctrl_pkg::ADDR_FROM_CTRL;
                reg_addr_o        = lowest_reg(pending);
                // PUSH fills from SP - 4n upward, so its offset shrinks per step
                if (is_push) begin
                    accum_imm_o = total_bytes - step_bytes;
                end else begin
                    accum_imm_o = step_bytes;
                end
            end else begin
                // final cycle writes the moved base back to the register file
                ctrl_o.mem_write = 1'b0;
                ctrl_o.reg_write = 1'b1;
                ctrl_o.dest_src  = cpu_ctrl_pkg::ADDR_FROM_CTRL;
                accum_imm_o      = total_bytes;
                if (is_push) begin
                    reg_addr_o = cpu_ctrl_pkg::reg_addr_t'(`SP_REG_NUM);
                end else begin
                    reg_addr_o = list_req_i.base;
                end
            end
        end
    end

    // any cycle without a stall rearms the sequencer for the next list instruction
    always_ff @(posedge clk_i) begin
        if (reset_i || !busy) begin
            hold_mask <= '1;
            step_k    <= '0;
        end else begin
            hold_mask <= hold_mask & ~lowest_bit;
            step_k    <= step_k + 1'b1;
        end
    end

endmodule

//--- cpu_controller.sv
`timescale 1ns/1ps

module cpu_controller (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  cpu_ctrl_pkg::instr_t     instr_i,
    output cpu_ctrl_pkg::ctrl_word_t ctrl_o,
    output logic                     valid_o,
    output logic                     stall_o,
    output cpu_ctrl_pkg::reg_addr_t  reg_addr_o,
    output cpu_ctrl_pkg::word_t      accum_imm_o
);

    cpu_ctrl_pkg::ctrl_word_t dec_ctrl;
    cpu_ctrl_pkg::list_req_t  list_req;

    // single-cycle decode, valid goes straight out
    thumb_decode u_decode (
        .instr_i    (instr_i),
        .ctrl_o     (dec_ctrl),
        .list_req_o (list_req),
        .valid_o    (valid_o)
    );

    // passes the decoded word through, or steps STM/PUSH one register per cycle
    reg_list_sequencer u_sequencer (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .dec_ctrl_i  (dec_ctrl),
        .list_req_i  (list_req),
        .ctrl_o      (ctrl_o),
        .stall_o     (stall_o),
        .reg_addr_o  (reg_addr_o),
        .accum_imm_o (accum_imm_o)
    );

endmodule

//--- tb_cases.svh
// shift by immediate, add/sub register and immediate, 8-bit immediate forms
alu_row(16'h0088, cpu_ctrl_pkg::ALU_LSL, 1'b0, 1'b1, 1'b1);
alu_row(16'h0888, cpu_ctrl_pkg::ALU_LSR, 1'b0, 1'b1, 1'b1);
alu_row(16'h1088, cpu_ctrl_pkg::ALU_ASR, 1'b0, 1'b1, 1'b1);
alu_row(16'h1853, cpu_ctrl_pkg::ALU_ADD, 1'b0, 1'b0, 1'b1);
alu_row(16'h1A53, cpu_ctrl_pkg::ALU_SUB, 1'b0, 1'b0, 1'b1);
alu_row(16'h1C53, cpu_ctrl_pkg::ALU_ADD, 1'b0, 1'b1, 1'b1);
alu_row(16'h1E53, cpu_ctrl_pkg::ALU_SUB, 1'b0, 1'b1, 1'b1);
alu_row(16'h2042, cpu_ctrl_pkg::ALU_ADD, 1'b1, 1'b1, 1'b1);
// CMP by immediate only sets the flags
alu_row(16'h2942, cpu_ctrl_pkg::ALU_SUB, 1'b0, 1'b1, 1'b0);
alu_row(16'h3142, cpu_ctrl_pkg::ALU_ADD, 1'b0, 1'b1, 1'b1);
alu_row(16'h3942, cpu_ctrl_pkg::ALU_SUB, 1'b0, 1'b1, 1'b1);
// the sixteen data-processing codes in bits 9:6
alu_row(16'h400A, cpu_ctrl_pkg::ALU_AND, 1'b0, 1'b0, 1'b1);
alu_row(16'h404A, cpu_ctrl_pkg::ALU_XOR, 1'b0, 1'b0, 1'b1);
alu_row(16'h408A, cpu_ctrl_pkg::ALU_LSL, 1'b0, 1'b0, 1'b1);
alu_row(16'h40CA, cpu_ctrl_pkg::ALU_LSR, 1'b0, 1'b0, 1'b1);
alu_row(16'h410A, cpu_ctrl_pkg::ALU_ASR, 1'b0, 1'b0, 1'b1);
alu_row(16'h414A, cpu_ctrl_pkg::ALU_ADD, 1'b0, 1'b0, 1'b1);
alu_row(16'h418A, cpu_ctrl_pkg::ALU_SUB, 1'b0, 1'b0, 1'b1);
alu_row(16'h41CA, cpu_ctrl_pkg::ALU_ROR, 1'b0, 1'b0, 1'b1);
alu_row(16'h420A, cpu_ctrl_pkg::ALU_AND, 1'b0, 1'b0, 1'b0);
alu_row(16'h424A, cpu_ctrl_pkg::ALU_SUB, 1'b1, 1'b0, 1'b1);
alu_row(16'h428A, cpu_ctrl_pkg::ALU_SUB, 1'b0, 1'b0, 1'b0);
alu_row(16'h42CA, cpu_ctrl_pkg::ALU_ADD, 1'b0, 1'b0, 1'b0);
alu_row(16'h430A, cpu_ctrl_pkg::ALU_OR, 1'b0, 1'b0, 1'b1);
alu_row(16'h434A, cpu_ctrl_pkg::ALU_MUL, 1'b0, 1'b0, 1'b1);
alu_row(16'h438A, cpu_ctrl_pkg::ALU_BIC, 1'b0, 1'b0, 1'b1);
alu_row(16'h43CA, cpu_ctrl_pkg::ALU_NOT, 1'b0, 1'b0, 1'b1);
// single loads and stores, register offset first
mem_row(16'h5088, 1'b0, 1'b0);
mem_row(16'h5688, 1'b1, 1'b0);
mem_row(16'h5888, 1'b1, 1'b0);
mem_row(16'h6088, 1'b0, 1'b1);
mem_row(16'h7888, 1'b1, 1'b1);
mem_row(16'h8088, 1'b0, 1'b1);
mem_row(16'h8888, 1'b1, 1'b1);
mem_row(16'h9288, 1'b0, 1'b1);
mem_row(16'h9A88, 1'b1, 1'b1);
// STM with r0, r3, r5 and r7 into base r2, then one register and an empty list
list_row(16'hC2A9, KIND_STM, 4);
list_row(16'hC502, KIND_STM, 1);
list_row(16'hC300, KIND_STM, 0);
list_row(16'hB400, KIND_PUSH, 0);
list_row(16'hB5FF, KIND_PUSH, 9);
// conditional branch, BL prefix, BX, POP and LDM are not decoded
bad_row(16'hD0FE);
bad_row(16'hF000);
bad_row(16'h4700);
bad_row(16'hBC01);
bad_row(16'hC901);

//--- tb_cpu_controller.sv
`timescale 1ns/1ps
`include "cpu_ctrl_defines.svh"

module tb_cpu_controller;

    localparam int CLK_NS       = 4;
    localparam int ROW_CYCLES   = 20;
    localparam int SLACK_CYCLES = 200;
    localparam int KIND_SINGLE  = 0;
    localparam int KIND_STM     = 1;
    localparam int KIND_PUSH    = 2;

    logic                     clk_i;
    logic                     reset_i;
    cpu_ctrl_pkg::instr_t     instr_i;
    cpu_ctrl_pkg::ctrl_word_t ctrl_o;
    logic                     valid_o;
    logic                     stall_o;
    cpu_ctrl_pkg::reg_addr_t  reg_addr_o;
    cpu_ctrl_pkg::word_t      accum_imm_o;

    // one entry per table row, list rows also carry their register count
    cpu_ctrl_pkg::instr_t     row_instr[$];
    cpu_ctrl_pkg::ctrl_word_t row_ctrl[$];
    logic                     row_valid[$];
    int                       row_kind[$];
    int                       row_n[$];

    int   error_count = 0;
    int   check_count = 0;
    int   seed        = 32'h96f2;
    int   watchdog_ns = 0;
    logic rows_ready  = 1'b0;

    cpu_controller uut (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .instr_i     (instr_i),
        .ctrl_o      (ctrl_o),
        .valid_o     (valid_o),
        .stall_o     (stall_o),
        .reg_addr_o  (reg_addr_o),
        .accum_imm_o (accum_imm_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_NS / 2) clk_i = ~clk_i;
    end

    // a register-to-register add with every enable off
    function automatic cpu_ctrl_pkg::ctrl_word_t idle_word();
        cpu_ctrl_pkg::ctrl_word_t w;
        w.update_flag = 1'b0;
        w.mem_read    = 1'b0;
        w.mem_write   = 1'b0;
        w.reg_write   = 1'b0;
        w.rf_data_src = cpu_ctrl_pkg::RF_FROM_ALU;
        w.alu_src_1   = cpu_ctrl_pkg::SRC_REG;
        w.alu_src_2   = cpu_ctrl_pkg::SRC_REG;
        w.alu_op      = cpu_ctrl_pkg::ALU_ADD;
        w.addr_2_src  = cpu_ctrl_pkg::ADDR_FROM_INSTR;
        w.dest_src    = cpu_ctrl_pkg::ADDR_FROM_INSTR;
        w.sel_reg_3   = 1'b0;
        return w;
    endfunction

    function automatic int first_reg(input cpu_ctrl_pkg::reg_list_t list);
        for (int i = 0; i < `HALF_WORD; i++) begin
            if (list[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic add_row(input cpu_ctrl_pkg::instr_t instr, input cpu_ctrl_pkg::ctrl_word_t w,
                           input logic valid, input int kind, input int n);
        row_instr.push_back(instr);
        row_ctrl.push_back(w);
        row_valid.push_back(valid);
        row_kind.push_back(kind);
        row_n.push_back(n);
    endtask

    task automatic alu_row(input cpu_ctrl_pkg::instr_t instr, input cpu_ctrl_pkg::alu_op_e op,
                           input logic zero_1, input logic imm_2, input logic writes);
        cpu_ctrl_pkg::ctrl_word_t w;
        w             = idle_word();
        w.update_flag = 1'b1;
        w.reg_write   = writes;
        w.alu_op      = op;
        w.alu_src_1   = zero_1 ? cpu_ctrl_pkg::SRC_ZERO : cpu_ctrl_pkg::SRC_REG;
        w.alu_src_2   = imm_2 ? cpu_ctrl_pkg::SRC_IMM : cpu_ctrl_pkg::SRC_REG;
        add_row(instr, w, 1'b1, KIND_SINGLE, 0);
    endtask

    task automatic mem_row(input cpu_ctrl_pkg::instr_t instr, input logic load, input logic imm);
        cpu_ctrl_pkg::ctrl_word_t w;
        w             = idle_word();
        w.mem_read    = load;
        w.reg_write   = load;
        w.rf_data_src = load ? cpu_ctrl_pkg::RF_FROM_MEM : cpu_ctrl_pkg::RF_FROM_ALU;
        w.mem_write   = !load;
        w.sel_reg_3   = !load;
        w.alu_src_2   = imm ? cpu_ctrl_pkg::SRC_IMM : cpu_ctrl_pkg::SRC_REG;
        add_row(instr, w, 1'b1, KIND_SINGLE, 0);
    endtask

    // the decoder's part of a list word, the sequencer adds the per-step fields
    task automatic list_row(input cpu_ctrl_pkg::instr_t instr, input int kind, input int n);
        cpu_ctrl_pkg::ctrl_word_t w;
        w           = idle_word();
        w.alu_src_2 = cpu_ctrl_pkg::SRC_ACCUM;
        w.alu_op    = (kind == KIND_PUSH) ? cpu_ctrl_pkg::ALU_SUB : cpu_ctrl_pkg::ALU_ADD;
        add_row(instr, w, 1'b1, kind, n);
    endtask

    task automatic bad_row(input cpu_ctrl_pkg::instr_t instr);
        add_row(instr, idle_word(), 1'b0, KIND_SINGLE, 0);
    endtask

    task automatic load_table();
        `include "tb_cases.svh"
    endtask

    // bit 8 of a random word decides whether LR joins the list
    task automatic random_push_rows(input int count);
        logic [31:0] r;
        for (int i = 0; i < count; i++) begin
            r = $random(seed);
            list_row({7'b1011_010, r[8:0]}, KIND_PUSH, $countones(r[8:0]));
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("error at %0t ns: %s expected 0x%0h, actual 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    // called in the first cycle of the instruction, which is held while stall_o is high
    task automatic check_list_sequence(input int idx);
        cpu_ctrl_pkg::ctrl_word_t w;
        cpu_ctrl_pkg::reg_list_t  remaining;
        int                       n;
        int                       reg_num;
        int                       base;
        logic                     push;
        n         = row_n[idx];
        push      = (row_kind[idx] == KIND_PUSH);
        remaining = cpu_ctrl_pkg::reg_list_t'(row_instr[idx][7:0]);
        if (push) begin
            remaining[`LR_REG_NUM] = row_instr[idx][8];
        end
        base = push ? `SP_REG_NUM : int'(row_instr[idx][10:8]);
        for (int k = 0; k <= n; k++) begin
            if (k > 0) begin
                @(negedge clk_i);
            end
            check_value("stall_o", 32'(k < n), 32'(stall_o));
            w = row_ctrl[idx];
            if (k < n) begin
                reg_num = first_reg(remaining);
                if (reg_num >= 0) begin
                    remaining[reg_num] = 1'b0;
                end
                w.mem_write  = 1'b1;
                w.addr_2_src = cpu_ctrl_pkg::ADDR_FROM_CTRL;
                check_value("reg_addr_o", 32'(reg_num), 32'(reg_addr_o));
                check_value("accum_imm_o",
                            32'(push ? `WORD_BYTES * (n - k) : `WORD_BYTES * k), accum_imm_o);
            end else begin
                w.reg_write = 1'b1;
                w.dest_src  = cpu_ctrl_pkg::ADDR_FROM_CTRL;
                check_value("reg_addr_o", 32'(base), 32'(reg_addr_o));
                check_value("accum_imm_o", 32'(`WORD_BYTES * n), accum_imm_o);
            end
            check_value("ctrl_o", 32'(w), 32'(ctrl_o));
        end
    endtask

    task automatic apply_row(input int idx);
        @(posedge clk_i);
        instr_i <= row_instr[idx];
        @(negedge clk_i);
        check_value("valid_o", 32'(row_valid[idx]), 32'(valid_o));
        if (row_kind[idx] == KIND_SINGLE) begin
            check_value("stall_o", 32'(0), 32'(stall_o));
            check_value("ctrl_o", 32'(row_ctrl[idx]), 32'(ctrl_o));
        end else begin
            check_list_sequence(idx);
        end
    endtask

    // two registers go out, then reset lands in the middle of the list while the
    // instruction is still presented, so only reset can send it back to its first register
    task automatic reset_during_list(input int idx);
        @(posedge clk_i);
        instr_i <= row_instr[idx];
        @(negedge clk_i);
        check_value("stall_o", 32'(1), 32'(stall_o));
        repeat (2) @(posedge clk_i);
        reset_i <= 1'b1;
        repeat (2) @(posedge clk_i);
        reset_i <= 1'b0;
        @(negedge clk_i);
        check_list_sequence(idx);
    endtask

    initial begin
        int mid_idx;
        reset_i = 1'b1;
        instr_i = '0;
        mid_idx = -1;
        load_table();
        random_push_rows(6);
        watchdog_ns = (row_instr.size() * ROW_CYCLES + SLACK_CYCLES) * CLK_NS;
        rows_ready  = 1'b1;
        repeat (8) @(posedge clk_i);
        reset_i <= 1'b0;
        for (int i = 0; i < row_instr.size(); i++) begin
            apply_row(i);
            if (mid_idx < 0 && row_kind[i] == KIND_STM && row_n[i] > 2) begin
                mid_idx = i;
            end
        end
        if (mid_idx >= 0) begin
            reset_during_list(mid_idx);
            apply_row(mid_idx);
        end else begin
            error_count++;
            $display("no STM row with more than two registers for the reset test");
        end
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        wait (rows_ready);
        #watchdog_ns;
        $display("timeout: the tests did not finish within %0d ns", watchdog_ns);
        $display("Test failed");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+.
cpu_ctrl_pkg.sv
thumb_decode.sv
reg_list_sequencer.sv
cpu_controller.sv
tb_cpu_controller.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu_controller \
    -f vlog.f -o sim_cpu_controller > build.log 2>&1 \
    && ./obj_dir/sim_cpu_controller > sim.log 2>&1 \
    && grep -q "^Test passed$" sim.log \
    && echo "simulation PASS" && exit 0 \
    || { cat build.log sim.log 2>/dev/null; echo "simulation FAIL"; exit 1; }
